/* common/rv_pkg.sv */
package rv_pkg;

    typedef logic [31:0] word_t;      // data or address word
    typedef logic [4:0]  reg_idx_t;   // register index
    typedef logic [2:0]  funct3_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // decoder output, consumed by exec, fsm and register file
    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        funct3_t  funct3;
        alu_op_e  alu_op;
        word_t    imm;
        logic     use_imm;    // operand b is imm
        logic     use_pc;     // operand a is pc
        logic     zero_a;     // operand a is zero (lui)
        logic     writes_rd;
        logic     is_load;
        logic     is_store;
        logic     halt;       // ebreak or unknown opcode
    } decoded_t;

    // one request on the shared memory port
    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } mem_req_t;

endpackage

/* src/pc_unit.sv */
module pc_unit #(
    parameter rv_pkg::word_t RESET_PC = 32'h0
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          pc_advance,
    input  logic          jump_en,
    input  rv_pkg::word_t jump_target,
    output rv_pkg::word_t pc,
    output rv_pkg::word_t snpc
);

    assign snpc = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset)
            pc <= RESET_PC;
        else if (pc_advance)
            pc <= jump_en ? jump_target : snpc;   // taken jump or next word
    end

    // targets from exec must keep word alignment
    pc_aligned_a : assert property (
        @(posedge clk) disable iff (reset)
        pc_advance |=> (pc[1:0] == 2'b00)
    );

endmodule

/* src/reg_file.sv */
module reg_file (
    input  logic             clk,
    input  logic             we,
    input  rv_pkg::decoded_t dec,
    input  rv_pkg::word_t    wdata,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data
);

    rv_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && dec.rd != '0)   // x0 never written
            regs[dec.rd] <= wdata;
    end

    assign rs1_data = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
    assign rs2_data = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

    // the x0 slot is left alone by every write
    x0_zero_a : assert property (
        @(posedge clk)
        we |=> (regs[0] === $past(regs[0]))
    );

endmodule

/* execute/decoder.sv */
module decoder (
    input  rv_pkg::word_t    inst,
    output rv_pkg::decoded_t dec
);

    rv_pkg::word_t   imm_i;
    rv_pkg::word_t   imm_s;
    rv_pkg::word_t   imm_b;
    rv_pkg::word_t   imm_u;
    rv_pkg::word_t   imm_j;
    rv_pkg::alu_op_e funct_op;
    logic            f7_bit5;

    assign f7_bit5 = inst[30];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // funct3/funct7 to alu op, for OP and OP_IMM
    always_comb begin
        case (inst[14:12])
            3'b000: begin
                if (inst[6:0] == rv_pkg::OP && f7_bit5)
                    funct_op = rv_pkg::ALU_SUB;
                else
                    funct_op = rv_pkg::ALU_ADD;   // addi never subtracts
            end
            3'b001:  funct_op = rv_pkg::ALU_SLL;
            3'b010:  funct_op = rv_pkg::ALU_SLT;
            3'b011:  funct_op = rv_pkg::ALU_SLTU;
            3'b100:  funct_op = rv_pkg::ALU_XOR;
            3'b101:  funct_op = f7_bit5 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  funct_op = rv_pkg::ALU_OR;
            default: funct_op = rv_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        dec        = '0;
        dec.opcode = rv_pkg::opcode_e'(inst[6:0]);
        dec.rd     = inst[11:7];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];
        dec.funct3 = inst[14:12];
        dec.alu_op = rv_pkg::ALU_ADD;

        case (dec.opcode)
            rv_pkg::OP: begin
                dec.alu_op    = funct_op;
                dec.writes_rd = 1'b1;
            end
            rv_pkg::OP_IMM: begin
                dec.alu_op    = funct_op;
                dec.imm       = imm_i;
                dec.use_imm   = 1'b1;
                dec.writes_rd = 1'b1;
            end
            rv_pkg::LOAD: begin
                dec.imm       = imm_i;
                dec.use_imm   = 1'b1;
                dec.is_load   = 1'b1;
                dec.writes_rd = 1'b1;
            end
            rv_pkg::STORE: begin
                dec.imm      = imm_s;
                dec.use_imm  = 1'b1;
                dec.is_store = 1'b1;
            end
            rv_pkg::BRANCH: begin
                dec.imm     = imm_b;   // alu forms pc + offset
                dec.use_imm = 1'b1;
                dec.use_pc  = 1'b1;
            end
            rv_pkg::LUI: begin
                dec.imm       = imm_u;
                dec.use_imm   = 1'b1;
                dec.zero_a    = 1'b1;
                dec.writes_rd = 1'b1;
            end
            rv_pkg::AUIPC: begin
                dec.imm       = imm_u;
                dec.use_imm   = 1'b1;
                dec.use_pc    = 1'b1;
                dec.writes_rd = 1'b1;
            end
            rv_pkg::JAL: begin
                dec.imm       = imm_j;
                dec.use_imm   = 1'b1;
                dec.use_pc    = 1'b1;
                dec.writes_rd = 1'b1;
            end
            rv_pkg::JALR: begin
                dec.imm       = imm_i;
                dec.use_imm   = 1'b1;
                dec.writes_rd = 1'b1;
            end
            default: dec.halt = 1'b1;   // ebreak and anything unknown
        endcase
    end

endmodule

/* execute/exec_unit.sv */
module exec_unit (
    input  rv_pkg::decoded_t dec,
    input  rv_pkg::word_t    rs1_data,
    input  rv_pkg::word_t    rs2_data,
    input  rv_pkg::word_t    pc,
    input  rv_pkg::word_t    snpc,
    output rv_pkg::word_t    result,
    output rv_pkg::word_t    mem_addr,
    output rv_pkg::word_t    store_data,
    output logic             jump_en,
    output rv_pkg::word_t    jump_target
);

    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b;
    rv_pkg::word_t alu_out;
    logic [4:0]    shamt;
    logic          is_jal;
    logic          is_jalr;
    logic          branch_taken;

    assign is_jal  = (dec.opcode == rv_pkg::JAL);
    assign is_jalr = (dec.opcode == rv_pkg::JALR);

    // operand a: zero for lui, pc for auipc/jal/branch, else rs1
    always_comb begin
        if (dec.zero_a)
            op_a = '0;
        else if (dec.use_pc)
            op_a = pc;
        else
            op_a = rs1_data;
    end

    assign op_b  = dec.use_imm ? dec.imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            rv_pkg::ALU_SUB:  alu_out = op_a - op_b;
            rv_pkg::ALU_SLL:  alu_out = op_a << shamt;
            rv_pkg::ALU_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU: alu_out = {31'b0, op_a < op_b};
            rv_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
            rv_pkg::ALU_SRL:  alu_out = op_a >> shamt;
            rv_pkg::ALU_SRA:  alu_out = $unsigned($signed(op_a) >>> shamt);
            rv_pkg::ALU_OR:   alu_out = op_a | op_b;
            rv_pkg::ALU_AND:  alu_out = op_a & op_b;
            default:          alu_out = op_a + op_b;
        endcase
    end

    // branch condition from funct3
    always_comb begin
        case (dec.funct3)
            3'b000:  branch_taken = (rs1_data == rs2_data);
            3'b001:  branch_taken = (rs1_data != rs2_data);
            3'b100:  branch_taken = $signed(rs1_data) < $signed(rs2_data);
            3'b101:  branch_taken = $signed(rs1_data) >= $signed(rs2_data);
            3'b110:  branch_taken = rs1_data < rs2_data;
            3'b111:  branch_taken = rs1_data >= rs2_data;
            default: branch_taken = 1'b0;
        endcase
    end

    assign jump_en = is_jal || is_jalr ||
                     (dec.opcode == rv_pkg::BRANCH && branch_taken);

    // jalr target has bit 0 cleared
    assign jump_target = is_jalr ? {alu_out[31:1], 1'b0} : alu_out;

    assign result     = (is_jal || is_jalr) ? snpc : alu_out;   // link value
    assign mem_addr   = rs1_data + dec.imm;
    assign store_data = rs2_data;

endmodule

/* src/core_fsm.sv */
module core_fsm (
    input  logic             clk,
    input  logic             reset,
    input  rv_pkg::decoded_t dec,
    input  rv_pkg::word_t    pc,
    input  rv_pkg::word_t    mem_addr,
    input  rv_pkg::word_t    store_data,
    input  rv_pkg::word_t    result,
    output rv_pkg::word_t    inst,
    output logic             pc_advance,
    output logic             rd_we,
    output rv_pkg::word_t    rd_data,
    output rv_pkg::mem_req_t mem_req,
    output logic             mem_valid,
    input  logic             mem_ack,
    input  rv_pkg::word_t    mem_rdata,
    output logic             halted
);

    typedef enum logic [2:0] {
        FETCH,
        EXECUTE,
        MEM,
        WRITEBACK,
        HALT
    } state_e;

    state_e           state;
    logic             ack_seen;   // ack taken, waiting for it to drop
    logic             in_bus;
    logic             bus_done;
    rv_pkg::word_t    load_word;

    assign in_bus   = (state == FETCH) || (state == MEM);
    assign bus_done = in_bus && ack_seen && !mem_ack;

    // fetch reads at pc, mem phase uses the exec address
    always_comb begin
        if (state == FETCH) begin
            mem_req.addr  = pc;
            mem_req.wdata = '0;
            mem_req.we    = 1'b0;
        end else begin
            mem_req.addr  = mem_addr;
            mem_req.wdata = store_data;
            mem_req.we    = dec.is_store;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= FETCH;
            mem_valid <= 1'b0;
            ack_seen  <= 1'b0;
        end else begin
            if (in_bus) begin
                if (!mem_valid && !ack_seen && !mem_ack) begin
                    mem_valid <= 1'b1;
                end else if (mem_valid && mem_ack) begin
                    mem_valid <= 1'b0;
                    ack_seen  <= 1'b1;
                end else if (bus_done) begin
                    ack_seen <= 1'b0;
                end
            end

            case (state)
                FETCH: if (bus_done) state <= EXECUTE;
                EXECUTE: begin
                    if (dec.halt)
                        state <= HALT;
                    else if (dec.is_load || dec.is_store)
                        state <= MEM;
                    else
                        state <= WRITEBACK;
                end
                MEM:       if (bus_done) state <= WRITEBACK;
                WRITEBACK: state <= FETCH;
                default:   state <= HALT;   // stays halted
            endcase
        end
    end

    // instruction and load word
    always_ff @(posedge clk) begin
        if (state == FETCH && mem_valid && mem_ack)
            inst <= mem_rdata;
        if (state == MEM && mem_valid && mem_ack && dec.is_load)
            load_word <= mem_rdata;
    end

    assign pc_advance = (state == WRITEBACK);
    assign rd_we      = (state == WRITEBACK) && dec.writes_rd;
    assign rd_data    = dec.is_load ? load_word : result;
    assign halted     = (state == HALT);

    // request held steady until the memory answers
    req_stable_a : assert property (
        @(posedge clk) disable iff (reset)
        mem_valid && !mem_ack |=> $stable(mem_req)
    );

endmodule

/* src/rv_core.sv */
module rv_core #(
    parameter rv_pkg::word_t RESET_PC = 32'h0
) (
    input  logic             clk,
    input  logic             reset,
    output rv_pkg::mem_req_t mem_req,
    output logic             mem_valid,
    input  logic             mem_ack,
    input  rv_pkg::word_t    mem_rdata,
    output logic             halted
);

    rv_pkg::decoded_t dec;
    rv_pkg::word_t    inst;
    rv_pkg::word_t    pc;
    rv_pkg::word_t    snpc;
    rv_pkg::word_t    rs1_data;
    rv_pkg::word_t    rs2_data;
    rv_pkg::word_t    result;
    rv_pkg::word_t    mem_addr;
    rv_pkg::word_t    store_data;
    rv_pkg::word_t    jump_target;
    rv_pkg::word_t    rd_data;
    logic             jump_en;
    logic             pc_advance;
    logic             rd_we;

    core_fsm u_core_fsm (
        .clk        (clk),
        .reset      (reset),
        .dec        (dec),
        .pc         (pc),
        .mem_addr   (mem_addr),
        .store_data (store_data),
        .result     (result),
        .inst       (inst),
        .pc_advance (pc_advance),
        .rd_we      (rd_we),
        .rd_data    (rd_data),
        .mem_req    (mem_req),
        .mem_valid  (mem_valid),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata),
        .halted     (halted)
    );

    pc_unit #(
        .RESET_PC (RESET_PC)
    ) u_pc_unit (
        .clk         (clk),
        .reset       (reset),
        .pc_advance  (pc_advance),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .pc          (pc),
        .snpc        (snpc)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .we       (rd_we),
        .dec      (dec),
        .wdata    (rd_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    decoder u_decoder (
        .inst (inst),
        .dec  (dec)
    );

    exec_unit u_exec_unit (
        .dec         (dec),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .pc          (pc),
        .snpc        (snpc),
        .result      (result),
        .mem_addr    (mem_addr),
        .store_data  (store_data),
        .jump_en     (jump_en),
        .jump_target (jump_target)
    );

endmodule

/* tests/tb_rv_core.sv */
module tb_rv_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam rv_pkg::word_t RESET_PC = 32'h0;
    localparam int MEM_WORDS    = 1024;
    localparam int WAIT_CYCLES  = 100;   // limit for every wait loop
    localparam int MAX_REQUESTS = 400;

    logic             clk;
    logic             reset;
    rv_pkg::mem_req_t mem_req;
    logic             mem_valid;
    logic             mem_ack;
    rv_pkg::word_t    mem_rdata;
    logic             halted;

    rv_pkg::word_t    mem [MEM_WORDS];
    rv_pkg::word_t    exp_addr [$];   // expected stores, in order
    rv_pkg::word_t    exp_data [$];
    logic             valid_q;
    rv_pkg::mem_req_t req_q;

    rv_core #(
        .RESET_PC (RESET_PC)
    ) uut (
        .clk       (clk),
        .reset     (reset),
        .mem_req   (mem_req),
        .mem_valid (mem_valid),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run(input string reason);
        $display("TEST FAIL");
        $fatal(1, reason);
    endtask

    task automatic compare_word(input string name, input rv_pkg::word_t expected,
                                input rv_pkg::word_t actual);
        assert (actual === expected) else begin
            $display("TEST FAIL");
            $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic compare_bit(input string name, input logic expected, input logic actual);
        assert (actual === expected) else begin
            $display("TEST FAIL");
            $display("Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
            $fatal(1, "value mismatch");
        end
    endtask

    // P lines fill memory, S lines queue expected stores
    task automatic load_stim_file();
        int            fd;
        int            n;
        string         line;
        string         kind;
        rv_pkg::word_t addr;
        rv_pkg::word_t data;
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = '0;
        fd = $fopen("tests/prog_stim.txt", "r");
        if (fd == 0)
            stop_run("could not open tests/prog_stim.txt");
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s %h %h", kind, addr, data);
            if (n == 3 && kind == "P") begin
                mem[addr[11:2]] = data;
            end else if (n == 3 && kind == "S") begin
                exp_addr.push_back(addr);
                exp_data.push_back(data);
            end
        end
        $fclose(fd);
    endtask

    task automatic wait_for_request();
        int waited;
        waited = 0;
        while (!mem_valid && !halted) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_CYCLES)
                stop_run("core neither made a request nor halted in time");
        end
    endtask

    // one four-phase transfer, ack after 0 to 3 cycles
    task automatic serve_request();
        rv_pkg::mem_req_t req;
        int               delay;
        int               hold;
        int               waited;
        req   = mem_req;
        assert (req.addr[1:0] == 2'b00)
            else stop_run("request address is not word aligned");
        delay = $urandom_range(3, 0);
        repeat (delay) @(negedge clk);
        if (req.we) begin
            assert (exp_addr.size() != 0)
                else stop_run("store seen after the last expected store");
            compare_word("mem_req.addr", exp_addr[0], req.addr);
            compare_word("mem_req.wdata", exp_data[0], req.wdata);
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
        end else begin
            mem_rdata <= mem[req.addr[11:2]];
        end
        mem_ack <= 1'b1;
        waited = 0;
        while (mem_valid) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_CYCLES)
                stop_run("mem_valid did not drop after mem_ack");
        end
        hold = $urandom_range(2, 0);   // ack may linger after valid drops
        repeat (hold) @(negedge clk);
        mem_ack <= 1'b0;
    endtask

    // handshake monitor, reads values before this edge's drives land
    always @(negedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            if (mem_valid && !valid_q)
                assert (!mem_ack) else stop_run("mem_valid rose while mem_ack was high");
            if (mem_valid && valid_q) begin
                compare_word("mem_req.addr", req_q.addr, mem_req.addr);
                compare_word("mem_req.wdata", req_q.wdata, mem_req.wdata);
                compare_bit("mem_req.we", req_q.we, mem_req.we);
            end
            valid_q <= mem_valid;
        end
        req_q <= mem_req;
    end

    initial begin
        int served;
        void'($urandom(32'h4142));
        reset     = 1'b1;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        served    = 0;
        load_stim_file();

        repeat (16) begin
            @(negedge clk);
            compare_bit("mem_valid", 1'b0, mem_valid);
            compare_bit("halted", 1'b0, halted);
        end
        reset <= 1'b0;

        while (!halted) begin
            wait_for_request();
            if (mem_valid) begin
                if (served == 0) begin   // first fetch
                    compare_word("mem_req.addr", RESET_PC, mem_req.addr);
                    compare_bit("mem_req.we", 1'b0, mem_req.we);
                end
                serve_request();
                served++;
                if (served > MAX_REQUESTS)
                    stop_run("program ran too long without halting");
            end
        end

        assert (exp_addr.size() == 0) else stop_run("core halted before all expected stores");
        repeat (20) begin
            @(negedge clk);
            compare_bit("mem_valid", 1'b0, mem_valid);
            compare_bit("halted", 1'b1, halted);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

/* tests/prog_stim.txt */
# P <addr> <word>: program or data word; S <addr> <data>: expected store, in order
# values in hex, text after the third column is ignored
P 000 800010b7  # lui   x1, 0x80001
P 004 ff000113  # addi  x2, x0, -16
P 008 00400193  # addi  x3, x0, 4
P 00c 20102023  # sw    x1, 0x200(x0)
P 010 00001217  # auipc x4, 0x1
P 014 20402223  # sw    x4, 0x204(x0)
P 018 002082b3  # add   x5, x1, x2
P 01c 20502423  # sw    x5, 0x208(x0)
P 020 402182b3  # sub   x5, x3, x2
P 024 20502623  # sw    x5, 0x20c(x0)
P 028 003112b3  # sll   x5, x2, x3
P 02c 20502823  # sw    x5, 0x210(x0)
P 030 003122b3  # slt   x5, x2, x3
P 034 20502a23  # sw    x5, 0x214(x0)
P 038 003132b3  # sltu  x5, x2, x3
P 03c 20502c23  # sw    x5, 0x218(x0)
P 040 0020c2b3  # xor   x5, x1, x2
P 044 20502e23  # sw    x5, 0x21c(x0)
P 048 003152b3  # srl   x5, x2, x3
P 04c 22502023  # sw    x5, 0x220(x0)
P 050 403152b3  # sra   x5, x2, x3
P 054 22502223  # sw    x5, 0x224(x0)
P 058 0030e2b3  # or    x5, x1, x3
P 05c 22502423  # sw    x5, 0x228(x0)
P 060 002272b3  # and   x5, x4, x2
P 064 22502623  # sw    x5, 0x22c(x0)
P 068 10002303  # lw    x6, 0x100(x0)
P 06c 01130313  # addi  x6, x6, 0x11
P 070 22602823  # sw    x6, 0x230(x0)
P 074 10002003  # lw    x0, 0x100(x0)
P 078 22002a23  # sw    x0, 0x234(x0)
P 07c 008003ef  # jal   x7, +8
P 080 3e002e23  # sw    x0, 0x3fc(x0)  must be skipped
P 084 09100493  # addi  x9, x0, 0x91
P 088 00048467  # jalr  x8, 0(x9)  lands on 0x90
P 08c 3e002e23  # sw    x0, 0x3fc(x0)  must be skipped
P 090 22702c23  # sw    x7, 0x238(x0)
P 094 22802e23  # sw    x8, 0x23c(x0)
P 098 00318463  # beq   x3, x3, +8  taken
P 09c 3e002e23  # sw    x0, 0x3fc(x0)
P 0a0 00311463  # bne   x2, x3, +8  taken
P 0a4 3e002e23  # sw    x0, 0x3fc(x0)
P 0a8 00314463  # blt   x2, x3, +8  taken
P 0ac 3e002e23  # sw    x0, 0x3fc(x0)
P 0b0 0021d463  # bge   x3, x2, +8  taken
P 0b4 3e002e23  # sw    x0, 0x3fc(x0)
P 0b8 0021e463  # bltu  x3, x2, +8  taken
P 0bc 3e002e23  # sw    x0, 0x3fc(x0)
P 0c0 00317463  # bgeu  x2, x3, +8  taken
P 0c4 3e002e23  # sw    x0, 0x3fc(x0)
P 0c8 00310e63  # beq   x2, x3, 0xe4  not taken
P 0cc 00319c63  # bne   x3, x3, 0xe4  not taken
P 0d0 0021ca63  # blt   x3, x2, 0xe4  not taken
P 0d4 00315863  # bge   x2, x3, 0xe4  not taken
P 0d8 00316663  # bltu  x2, x3, 0xe4  not taken
P 0dc 0021f463  # bgeu  x3, x2, 0xe4  not taken
P 0e0 24302023  # sw    x3, 0x240(x0)  marker
P 0e4 00100073  # ebreak
P 100 00abc000  # load source word
S 200 80001000  # lui
S 204 00001010  # auipc
S 208 80000ff0  # add
S 20c 00000014  # sub
S 210 ffffff00  # sll
S 214 00000001  # slt
S 218 00000000  # sltu
S 21c 7fffeff0  # xor
S 220 0fffffff  # srl
S 224 ffffffff  # sra on a negative value
S 228 80001004  # or
S 22c 00001010  # and
S 230 00abc011  # loaded word plus 0x11
S 234 00000000  # x0 after load
S 238 00000080  # jal link
S 23c 0000008c  # jalr link
S 240 00000004  # marker after not-taken branches

/* sim.f */
common/rv_pkg.sv
src/pc_unit.sv
src/reg_file.sv
execute/decoder.sv
execute/exec_unit.sv
src/core_fsm.sv
src/rv_core.sv
tests/tb_rv_core.sv
